/* design/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram
  import rv_core_pkg::*;
(
  input  wire                  clk,
  input  wire [RAM_AWIDTH-1:0] addr_i,
  input  wire                  wen_i,
  input  wire [7:0]            wmask_i,
  input  wire [XLEN-1:0]       wdata_i,
  output wire [XLEN-1:0]       rdata_o
);

  // doubleword storage, no reset
  // contents come from stores only
  logic [XLEN-1:0] mem_q [RAM_DEPTH];

  // byte-lane write
  // lanes with a clear mask bit keep their old value
  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // combinational read, same cycle as the address
  assign rdata_o = mem_q[addr_i];

endmodule

`default_nettype wire

/* design/gpr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module gpr_file
  import rv_core_pkg::*;
(
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire                      wen_i,
  input  wire  [REG_ADDRWIDTH-1:0] waddr_i,
  input  wire  [XLEN-1:0]          wdata_i,
  input  wire  [REG_ADDRWIDTH-1:0] rs_addr_i,
  output wire  [XLEN-1:0]          rs_data_o
);

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  // single write port, cleared on reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // combinational read
  // no bypass, a same-cycle write shows up next cycle
  assign rs_data_o = (rs_addr_i == '0) ? '0 : regs_q[rs_addr_i];

endmodule

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage
  import rv_core_pkg::*;
(
  input  wire  [XLEN-1:0]          pc_i,
  input  wire  [INST_LEN-1:0]      inst_i,
  input  wire  [XLEN-1:0]          alu_data_i,
  input  wire  [XLEN-1:0]          store_data_i,
  input  wire                      flush_i,
  output wire  [RAM_AWIDTH-1:0]    ram_addr_o,
  output wire                      ram_wen_o,
  output logic [7:0]               ram_wmask_o,
  output logic [XLEN-1:0]          ram_wdata_o,
  input  wire  [XLEN-1:0]          ram_rdata_i,
  output wire  [XLEN-1:0]          pc_o,
  output wire  [INST_LEN-1:0]      inst_o,
  output wire  [REG_ADDRWIDTH-1:0] rd_addr_o,
  output wire  [XLEN-1:0]          mem_data_o
);

  wire [INST_LEN-1:0]      inst;
  wire [6:0]               opcode;
  wire [2:0]               funct3;
  wire [RAM_BYTE_BITS-1:0] byte_off;
  wire [XLEN-1:0]          rdata_shift;
  logic [XLEN-1:0]         load_data;

  // flush turns the slot into a nop at pc 0
  // the nop is not a store, so the ram write drops out too
  assign inst   = flush_i ? INST_NOP : inst_i;
  assign pc_o   = flush_i ? '0 : pc_i;
  assign inst_o = inst;

  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign rd_addr_o = inst[11:7];

  // doubleword index from addr[8:3], byte lane from addr[2:0]
  assign ram_addr_o = alu_data_i[RAM_AWIDTH+RAM_BYTE_BITS-1:RAM_BYTE_BITS];
  assign byte_off   = alu_data_i[RAM_BYTE_BITS-1:0];

  assign ram_wen_o = (opcode == OPC_STORE);

  // store data copied into every lane, mask picks the real ones
  // address is assumed aligned to the size
  always_comb begin
    case (funct3)
      F3_B: begin
        ram_wdata_o = {8{store_data_i[7:0]}};
        ram_wmask_o = 8'b0000_0001 << byte_off;
      end
      F3_H: begin
        ram_wdata_o = {4{store_data_i[15:0]}};
        ram_wmask_o = 8'b0000_0011 << byte_off;
      end
      F3_W: begin
        ram_wdata_o = {2{store_data_i[31:0]}};
        ram_wmask_o = 8'b0000_1111 << byte_off;
      end
      default: begin
        // sd and anything unexpected write the whole doubleword
        ram_wdata_o = store_data_i;
        ram_wmask_o = 8'hff;
      end
    endcase
  end

  // addressed byte moved down to bit 0
  assign rdata_shift = ram_rdata_i >> {byte_off, 3'b000};

  // size select plus sign or zero extension
  always_comb begin
    case (funct3)
      F3_B:    load_data = {{(XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
      F3_H:    load_data = {{(XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
      F3_W:    load_data = {{(XLEN-32){rdata_shift[31]}}, rdata_shift[31:0]};
      F3_BU:   load_data = {{(XLEN-8){1'b0}}, rdata_shift[7:0]};
      F3_HU:   load_data = {{(XLEN-16){1'b0}}, rdata_shift[15:0]};
      F3_WU:   load_data = {{(XLEN-32){1'b0}}, rdata_shift[31:0]};
      default: load_data = ram_rdata_i;
    endcase
  end

  // loads take ram data, everything else keeps the alu result
  assign mem_data_o = (opcode == OPC_LOAD) ? load_data : alu_data_i;

endmodule

`default_nettype wire

/* design/mem_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb
  import rv_core_pkg::*;
(
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire                      stall_i,
  input  wire  [XLEN-1:0]          pc_i,
  input  wire  [INST_LEN-1:0]      inst_i,
  input  wire  [REG_ADDRWIDTH-1:0] rd_addr_i,
  input  wire  [XLEN-1:0]          mem_data_i,
  output logic [XLEN-1:0]          pc_o,
  output logic [INST_LEN-1:0]      inst_o,
  output logic [REG_ADDRWIDTH-1:0] rd_addr_o,
  output logic [XLEN-1:0]          mem_data_o
);

  // one load enable for all fields
  wire reg_en = ~stall_i;

  // pc of the retiring instruction
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o <= '0;
    end else if (reg_en) begin
      pc_o <= pc_i;
    end
  end

  // instruction word, comes out of reset as a nop
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_o <= INST_NOP;
    end else if (reg_en) begin
      inst_o <= inst_i;
    end
  end

  // destination register index
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_addr_o <= '0;
    end else if (reg_en) begin
      rd_addr_o <= rd_addr_i;
    end
  end

  // load data or alu result
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_data_o <= '0;
    end else if (reg_en) begin
      mem_data_o <= mem_data_i;
    end
  end

endmodule

`default_nettype wire

/* design/mem_wb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb_top
  import rv_core_pkg::*;
(
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire  [XLEN-1:0]          pc_i,
  input  wire  [INST_LEN-1:0]      inst_i,
  input  wire  [XLEN-1:0]          alu_data_i,
  input  wire  [XLEN-1:0]          store_data_i,
  input  wire                      stall_i,
  input  wire                      flush_i,
  input  wire  [REG_ADDRWIDTH-1:0] rs_addr_i,
  output wire  [XLEN-1:0]          wb_pc_o,
  output wire  [INST_LEN-1:0]      wb_inst_o,
  output wire  [XLEN-1:0]          rs_data_o
);

  // memory stage to ram
  wire [RAM_AWIDTH-1:0]    ram_addr;
  wire                     ram_wen;
  wire [7:0]               ram_wmask;
  wire [XLEN-1:0]          ram_wdata;
  wire [XLEN-1:0]          ram_rdata;

  // memory stage to mem_wb
  wire [XLEN-1:0]          pc;
  wire [INST_LEN-1:0]      inst;
  wire [REG_ADDRWIDTH-1:0] rd_addr;
  wire [XLEN-1:0]          mem_data;

  // mem_wb outputs
  wire [REG_ADDRWIDTH-1:0] wb_rd_addr;
  wire [XLEN-1:0]          wb_mem_data;

  // writeback to register file
  wire                     gpr_wen;
  wire [REG_ADDRWIDTH-1:0] gpr_waddr;
  wire [XLEN-1:0]          gpr_wdata;

  mem_stage u_mem_stage (
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .alu_data_i   (alu_data_i),
    .store_data_i (store_data_i),
    .flush_i      (flush_i),
    .ram_addr_o   (ram_addr),
    .ram_wen_o    (ram_wen),
    .ram_wmask_o  (ram_wmask),
    .ram_wdata_o  (ram_wdata),
    .ram_rdata_i  (ram_rdata),
    .pc_o         (pc),
    .inst_o       (inst),
    .rd_addr_o    (rd_addr),
    .mem_data_o   (mem_data)
  );

  data_ram u_data_ram (
    .clk     (clk),
    .addr_i  (ram_addr),
    .wen_i   (ram_wen),
    .wmask_i (ram_wmask),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  // stall holds the retiring instruction in place
  mem_wb u_mem_wb (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall_i),
    .pc_i       (pc),
    .inst_i     (inst),
    .rd_addr_i  (rd_addr),
    .mem_data_i (mem_data),
    .pc_o       (wb_pc_o),
    .inst_o     (wb_inst_o),
    .rd_addr_o  (wb_rd_addr),
    .mem_data_o (wb_mem_data)
  );

  wb_stage u_wb_stage (
    .inst_i      (wb_inst_o),
    .rd_addr_i   (wb_rd_addr),
    .mem_data_i  (wb_mem_data),
    .gpr_wen_o   (gpr_wen),
    .gpr_waddr_o (gpr_waddr),
    .gpr_wdata_o (gpr_wdata)
  );

  gpr_file u_gpr_file (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .wen_i     (gpr_wen),
    .waddr_i   (gpr_waddr),
    .wdata_i   (gpr_wdata),
    .rs_addr_i (rs_addr_i),
    .rs_data_o (rs_data_o)
  );

endmodule

`default_nettype wire

/* design/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // datapath widths
  localparam int XLEN          = 64;
  localparam int INST_LEN      = 32;
  localparam int REG_ADDRWIDTH = 5;

  // data ram geometry, one entry per doubleword
  localparam int RAM_DEPTH  = 64;
  localparam int RAM_AWIDTH = 6;
  // byte offset bits below the doubleword index
  localparam int RAM_BYTE_BITS = 3;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // funct3 access size and sign, shared by loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_D  = 3'b011;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;
  localparam logic [2:0] F3_WU = 3'b110;

  // addi x0, x0, 0
  localparam logic [INST_LEN-1:0] INST_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

/* design/wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_stage
  import rv_core_pkg::*;
(
  input  wire  [INST_LEN-1:0]      inst_i,
  input  wire  [REG_ADDRWIDTH-1:0] rd_addr_i,
  input  wire  [XLEN-1:0]          mem_data_i,
  output logic                     gpr_wen_o,
  output wire  [REG_ADDRWIDTH-1:0] gpr_waddr_o,
  output wire  [XLEN-1:0]          gpr_wdata_o
);

  wire [6:0] opcode  = inst_i[6:0];
  wire       rd_zero = (rd_addr_i == '0);

  // opcodes that produce a result in rd
  // x0 targets never write
  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_LUI,
      OPC_AUIPC, OPC_JAL, OPC_JALR: gpr_wen_o = ~rd_zero;
      // stores, branches and anything else retire silently
      default:                      gpr_wen_o = 1'b0;
    endcase
  end

  assign gpr_waddr_o = rd_addr_i;
  assign gpr_wdata_o = mem_data_i;

endmodule

`default_nettype wire

/* list.f */
design/rv_core_pkg.sv
design/data_ram.sv
design/mem_stage.sv
design/mem_wb.sv
design/wb_stage.sv
design/gpr_file.sv
design/mem_wb_top.sv
sim/tb_mem_wb_top.sv

/* sim/tb_mem_wb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_wb_top
  import rv_core_pkg::*;
();

  // 1500 instructions, about one in five adds a stall cycle, plus reset and drain
  localparam int N_INSTR        = 1500;
  localparam int N_PRELOAD      = RAM_DEPTH;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                     clk = 1'b0;
  logic                     arst_n_i;
  logic [XLEN-1:0]          pc_i;
  logic [INST_LEN-1:0]      inst_i;
  logic [XLEN-1:0]          alu_data_i;
  logic [XLEN-1:0]          store_data_i;
  logic                     stall_i;
  logic                     flush_i;
  logic [REG_ADDRWIDTH-1:0] rs_addr_i;
  wire  [XLEN-1:0]          wb_pc_o;
  wire  [INST_LEN-1:0]      wb_inst_o;
  wire  [XLEN-1:0]          rs_data_o;

  // reference state: ram, registers, shadow mem_wb
  logic [XLEN-1:0]          ram_model [RAM_DEPTH];
  logic [XLEN-1:0]          regs_model [32];
  logic [XLEN-1:0]          sh_pc;
  logic [INST_LEN-1:0]      sh_inst;
  logic [REG_ADDRWIDTH-1:0] sh_rd;
  logic [XLEN-1:0]          sh_data;
  // memory stage view of the current cycle
  logic [INST_LEN-1:0]      cur_inst;
  logic [XLEN-1:0]          cur_pc;
  logic [XLEN-1:0]          cur_data;

  logic [31:0]              rng_state = 32'he44cf133;
  logic [XLEN-1:0]          pc_next = '0;
  logic [5:0]               last_dw = '0;
  int                       cycle_count = 0;

  mem_wb_top u_dut (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .alu_data_i   (alu_data_i),
    .store_data_i (store_data_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .rs_addr_i    (rs_addr_i),
    .wb_pc_o      (wb_pc_o),
    .wb_inst_o    (wb_inst_o),
    .rs_data_o    (rs_data_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // expected load value from a model doubleword
  // halves and words indexed by their aligned slot
  function automatic logic [XLEN-1:0] load_result(input logic [XLEN-1:0] dw_val,
                                                  input logic [2:0] off,
                                                  input logic [2:0] f3);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    b = dw_val[off*8 +: 8];
    h = dw_val[off[2:1]*16 +: 16];
    w = dw_val[off[2]*32 +: 32];
    case (f3)
      F3_B:    return {{56{b[7]}}, b};
      F3_H:    return {{48{h[15]}}, h};
      F3_W:    return {{32{w[31]}}, w};
      F3_BU:   return {56'b0, b};
      F3_HU:   return {48'b0, h};
      F3_WU:   return {32'b0, w};
      default: return dw_val;
    endcase
  endfunction

  // opcodes that retire into rd
  function automatic logic produces_result(input logic [6:0] opc);
    return (opc == OPC_LOAD) || (opc == OPC_OP) || (opc == OPC_OP_IMM) ||
           (opc == OPC_LUI) || (opc == OPC_AUIPC) || (opc == OPC_JAL) ||
           (opc == OPC_JALR);
  endfunction

  // size from funct3[1:0], one byte at a time
  task automatic store_bytes(input logic [5:0] dw, input logic [2:0] off,
                             input logic [2:0] f3, input logic [XLEN-1:0] data);
    int size;
    size = 1 << f3[1:0];
    for (int i = 0; i < size; i++) begin
      ram_model[dw][(off+i)*8 +: 8] = data[i*8 +: 8];
    end
  endtask

  task automatic expect_equal(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // reference update at the rising edge
  // load reads the ram before this cycle's store, retiring write uses the old shadow
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sh_pc   = '0;
      sh_inst = INST_NOP;
      sh_rd   = '0;
      sh_data = '0;
      for (int i = 0; i < 32; i++) begin
        regs_model[i] = '0;
      end
    end else begin
      cur_inst = flush_i ? INST_NOP : inst_i;
      cur_pc   = flush_i ? '0 : pc_i;
      if (cur_inst[6:0] == OPC_LOAD) begin
        cur_data = load_result(ram_model[alu_data_i[8:3]], alu_data_i[2:0], cur_inst[14:12]);
      end else begin
        cur_data = alu_data_i;
      end
      if (produces_result(sh_inst[6:0]) && (sh_rd != '0)) begin
        regs_model[sh_rd] = sh_data;
      end
      // stalled store rewrites the same bytes
      if (cur_inst[6:0] == OPC_STORE) begin
        store_bytes(alu_data_i[8:3], alu_data_i[2:0], cur_inst[14:12], store_data_i);
      end
      if (!stall_i) begin
        sh_pc   = cur_pc;
        sh_inst = cur_inst;
        sh_rd   = cur_inst[11:7];
        sh_data = cur_data;
      end
    end
  end

  // compare 1 ns after the edge, before the next falling-edge drive
  always @(posedge clk) begin
    #1;
    if (arst_n_i) begin
      expect_equal("wb_pc_o", sh_pc, wb_pc_o);
      expect_equal("wb_inst_o", sh_inst, wb_inst_o);
      expect_equal("rs_data_o", regs_model[rs_addr_i], rs_data_o);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // one instruction, optional stall cycle with inputs held
  task automatic issue(input logic [INST_LEN-1:0] inst, input logic [XLEN-1:0] alu,
                       input logic [XLEN-1:0] sdata, input logic flush, input logic stall,
                       input logic [REG_ADDRWIDTH-1:0] rs);
    pc_next      = pc_next + 4;
    pc_i         = pc_next;
    inst_i       = inst;
    alu_data_i   = alu;
    store_data_i = sdata;
    flush_i      = flush;
    rs_addr_i    = rs;
    if (stall) begin
      stall_i = 1'b1;
      @(negedge clk);
    end
    stall_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic issue_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [5:0]  dw;
    logic [2:0]  off;
    logic [XLEN-1:0] alu;
    draw_random(r0);
    draw_random(r1);
    draw_random(r2);
    draw_random(r3);
    draw_random(r4);
    f3 = r1[2:0];
    case (r0[2:0])
      3'd0, 3'd1: begin
        opc = OPC_LOAD;
        // 3'b111 is not a load, fold it onto ld
        if (f3 == 3'b111) f3 = F3_D;
      end
      3'd2, 3'd3: begin
        opc = OPC_STORE;
        f3  = {1'b0, r1[1:0]};
      end
      3'd4:    opc = OPC_OP;
      3'd5:    opc = OPC_OP_IMM;
      3'd6:    opc = r1[3] ? OPC_LUI : OPC_JAL;
      default: opc = OPC_BRANCH;
    endcase
    // a quarter of accesses reuse the previous doubleword
    dw  = (r0[4:3] == 2'b00) ? last_dw : r2[5:0];
    off = r2[8:6] & (3'b111 << f3[1:0]);
    if ((opc == OPC_LOAD) || (opc == OPC_STORE)) begin
      alu     = {55'b0, dw, off};
      last_dw = dw;
    end else begin
      alu = {r3, r4};
    end
    issue({r1[31:15], f3, r2[13:9], opc}, alu, {r4, r3},
          r0[31:24] < 8'd26, r0[23:16] < 8'd51, r2[31:27]);
  endtask

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    arst_n_i     = 1'b0;
    pc_i         = '0;
    inst_i       = INST_NOP;
    alu_data_i   = '0;
    store_data_i = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    rs_addr_i    = '0;
    for (int i = 0; i < RAM_DEPTH; i++) begin
      ram_model[i] = '0;
    end
    repeat (2) @(negedge clk);
    // retiring slot sits at pc 0 with a nop while reset is held
    expect_equal("wb_pc_o", '0, wb_pc_o);
    expect_equal("wb_inst_o", INST_NOP, wb_inst_o);
    arst_n_i = 1'b1;
    // fill every doubleword with sd, reading x0..x31 while all are still zero
    for (int i = 0; i < N_PRELOAD; i++) begin
      draw_random(ra);
      draw_random(rb);
      draw_random(rc);
      issue({ra[31:15], F3_D, ra[4:0], OPC_STORE}, XLEN'(i) << 3, {rb, rc},
            1'b0, 1'b0, REG_ADDRWIDTH'(i));
    end
    for (int n = N_PRELOAD; n < N_INSTR; n++) begin
      issue_random();
    end
    // drain the last results into the register file
    for (int i = 0; i < 3; i++) begin
      draw_random(ra);
      issue(INST_NOP, '0, '0, 1'b0, 1'b0, ra[4:0]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
